//--- stream_pkg.sv
package stream_pkg;

    // Data word width on the narrow side
    localparam int WORD_W = 32;

    // One data word from the source
    typedef logic [WORD_W-1:0] word_t;

    // FIFO entry, last flag sits above the word
    typedef logic [WORD_W:0] entry_t;

    // Output beat, word 0 in the low half
    typedef logic [2*WORD_W-1:0] beat_t;

    // Fill or free level of the FIFO
    typedef logic [15:0] count_t;

    // Valid words in a beat, 1 or 2 when a beat is present
    typedef logic [1:0] words_t;

    // Kind of the packer's most recent read decision
    typedef enum logic [1:0] {
        PACK_IDLE,   // Nothing read
        PACK_PAIR,   // Two words read as one beat
        PACK_SINGLE  // Final word of an odd packet
    } pack_state_t;

endpackage

//--- multififo_w1_r2.sv
`timescale 1ns/100ps

module multififo_w1_r2 #(
    parameter int WIDTH = 33,
    parameter int DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  softreset,
    input  logic [0:0]            writes,
    input  logic [1:0]            reads,
    input  logic [WIDTH-1:0]      din,
    output logic [1:0][WIDTH-1:0] dout,
    output logic                  taken,
    output stream_pkg::count_t    count,
    output stream_pkg::count_t    frees
);

    // Wide enough to hold a pointer plus two before the wrap
    localparam int PTR_W = $clog2(DEPTH + 2);
    localparam int ADDR_W = $clog2(DEPTH); // Wrapped pointers stay below DEPTH
    localparam logic [PTR_W-1:0] DEPTH_P = PTR_W'(DEPTH);

    logic [WIDTH-1:0]   mem [DEPTH];
    logic [PTR_W-1:0]   wptr;
    logic [PTR_W-1:0]   rptr;
    logic [PTR_W-1:0]   rptr_second;
    stream_pkg::count_t write_n;
    stream_pkg::count_t read_n;
    logic               ok_write;
    logic               ok_read;

    function automatic logic [PTR_W-1:0] wrap(input logic [PTR_W-1:0] p);
        return (p >= DEPTH_P) ? p - DEPTH_P : p;
    endfunction

    assign write_n  = stream_pkg::count_t'(writes);
    assign read_n   = stream_pkg::count_t'(reads);
    assign ok_write = (count + write_n) <= stream_pkg::count_t'(DEPTH);
    assign ok_read  = (reads <= 2'd2) && (read_n <= count); // Oversized request refused whole
    assign taken    = ok_write;
    assign frees    = stream_pkg::count_t'(DEPTH) - count;

    // Head pair, read combinationally
    assign rptr_second = wrap(rptr + 1'b1);
    assign dout[0]     = (count != '0) ? mem[rptr[ADDR_W-1:0]] : '0;
    assign dout[1]     = (count > stream_pkg::count_t'(1)) ? mem[rptr_second[ADDR_W-1:0]] : '0;

    always_ff @(posedge clk) begin
        if (ok_write && writes[0]) begin
            mem[wptr[ADDR_W-1:0]] <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else if (softreset) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (ok_write) begin
                wptr <= wrap(wptr + PTR_W'(writes));
            end
            if (ok_read) begin
                rptr <= wrap(rptr + PTR_W'(reads));
            end
            count <= count + (ok_write ? write_n : '0) - (ok_read ? read_n : '0); // Net change
        end
    end

    // The packer must never ask for more than is stored
    a_read_within_count: assert property (
        @(posedge clk) disable iff (!rst_n)
        read_n <= count
    ) else $error("FIFO read of %0d with only %0d entries stored", reads, count);

endmodule

//--- pair_packer.sv
`timescale 1ns/100ps

module pair_packer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush,
    input  stream_pkg::entry_t [1:0] fifo_dout,
    input  stream_pkg::count_t       fifo_count,
    output stream_pkg::words_t       fifo_reads,
    output logic                     pack_valid,
    output stream_pkg::beat_t        pack_data,
    output stream_pkg::words_t       pack_words,
    output logic                     pack_last
);

    stream_pkg::word_t       word0;
    stream_pkg::word_t       word1;
    logic                    last0;
    logic                    last1;
    stream_pkg::pack_state_t pack_state;

    assign word0 = fifo_dout[0][stream_pkg::WORD_W-1:0];
    assign word1 = fifo_dout[1][stream_pkg::WORD_W-1:0];
    assign last0 = fifo_dout[0][stream_pkg::WORD_W]; // Head entry closes its packet
    assign last1 = fifo_dout[1][stream_pkg::WORD_W];

    // Read decision from the current FIFO state
    always_comb begin
        if (fifo_count == '0) begin
            fifo_reads = 2'd0;
        end else if (fifo_count == stream_pkg::count_t'(1)) begin
            fifo_reads = last0 ? 2'd1 : 2'd0; // Wait for a partner word
        end else begin
            fifo_reads = last0 ? 2'd1 : 2'd2;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pack_valid <= 1'b0;
            pack_words <= 2'd0;
            pack_last  <= 1'b0;
            pack_state <= stream_pkg::PACK_IDLE;
        end else if (flush) begin
            pack_valid <= 1'b0;
            pack_words <= 2'd0;
            pack_last  <= 1'b0;
            pack_state <= stream_pkg::PACK_IDLE;
        end else begin
            pack_valid <= (fifo_reads != 2'd0);
            pack_words <= fifo_reads;
            case (fifo_reads)
                2'd2: begin
                    pack_last  <= last1;
                    pack_state <= stream_pkg::PACK_PAIR;
                end
                2'd1: begin
                    pack_last  <= last0;
                    pack_state <= stream_pkg::PACK_SINGLE;
                end
                default: begin
                    pack_last  <= 1'b0;
                    pack_state <= stream_pkg::PACK_IDLE;
                end
            endcase
        end
    end

    // Beat payload, only loaded when words are read
    always_ff @(posedge clk) begin
        if (fifo_reads == 2'd2) begin
            pack_data <= {word1, word0};
        end else if (fifo_reads == 2'd1) begin
            pack_data <= {{stream_pkg::WORD_W{1'b0}}, word0}; // High half zero
        end
    end

    a_words_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        pack_valid |-> (pack_words == 2'd1 || pack_words == 2'd2)
    ) else $error("Packer beat with word count %0d", pack_words);

    // A lone word with a partner available must be the end of a packet
    a_no_early_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        (fifo_count >= stream_pkg::count_t'(2))
            |=> (pack_state != stream_pkg::PACK_SINGLE) || pack_last
    ) else $error("Single word beat without last while a pair was stored");

endmodule

//--- frame_checksum.sv
`timescale 1ns/100ps

module frame_checksum (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               pack_valid,
    input  stream_pkg::beat_t  pack_data,
    input  stream_pkg::words_t pack_words,
    input  logic               pack_last,
    output logic               out_valid,
    output stream_pkg::beat_t  out_data,
    output stream_pkg::words_t out_words,
    output logic               out_last,
    output stream_pkg::word_t  out_checksum
);

    stream_pkg::word_t word_lo;
    stream_pkg::word_t word_hi;
    stream_pkg::word_t beat_sum;
    stream_pkg::word_t acc;

    assign word_lo  = pack_data[stream_pkg::WORD_W-1:0];
    assign word_hi  = pack_data[2*stream_pkg::WORD_W-1:stream_pkg::WORD_W];
    assign beat_sum = word_lo + ((pack_words == 2'd2) ? word_hi : '0); // Mod 2^32

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid    <= 1'b0;
            out_last     <= 1'b0;
            out_checksum <= '0;
            acc          <= '0;
        end else if (flush) begin
            out_valid    <= 1'b0;
            out_last     <= 1'b0;
            out_checksum <= '0;
            acc          <= '0;
        end else begin
            out_valid <= pack_valid;
            out_last  <= pack_valid && pack_last;
            if (pack_valid && pack_last) begin
                out_checksum <= acc + beat_sum; // Completed packet sum
                acc          <= '0;
            end else begin
                out_checksum <= '0;
                if (pack_valid) begin
                    acc <= acc + beat_sum;
                end
            end
        end
    end

    // Beat payload toward the sink
    always_ff @(posedge clk) begin
        if (pack_valid) begin
            out_data  <= pack_data;
            out_words <= pack_words;
        end
    end

    a_checksum_only_on_last: assert property (
        @(posedge clk) disable iff (!rst_n)
        !out_last |-> (out_checksum == '0)
    ) else $error("Checksum %h shown on a beat without last", out_checksum);

endmodule

//--- wide_stream_top.sv
`timescale 1ns/100ps

module wide_stream_top #(
    parameter int DEPTH = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               din_valid,
    input  stream_pkg::word_t  din,
    input  logic               din_last,
    output logic               taken,
    output stream_pkg::count_t frees,
    output logic               out_valid,
    output stream_pkg::beat_t  out_data,
    output stream_pkg::words_t out_words,
    output logic               out_last,
    output stream_pkg::word_t  out_checksum
);

    stream_pkg::entry_t       fifo_din;
    stream_pkg::entry_t [1:0] fifo_dout;
    stream_pkg::count_t       fifo_count;
    stream_pkg::words_t       fifo_reads;
    logic                     pack_valid;
    stream_pkg::beat_t        pack_data;
    stream_pkg::words_t       pack_words;
    logic                     pack_last;

    assign fifo_din = {din_last, din}; // Flag rides above the word

    multififo_w1_r2 #(
        .WIDTH($bits(stream_pkg::entry_t)),
        .DEPTH(DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .softreset (flush),
        .writes    (din_valid),
        .reads     (fifo_reads),
        .din       (fifo_din),
        .dout      (fifo_dout),
        .taken     (taken),
        .count     (fifo_count),
        .frees     (frees)
    );

    pair_packer u_packer (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .fifo_dout  (fifo_dout),
        .fifo_count (fifo_count),
        .fifo_reads (fifo_reads),
        .pack_valid (pack_valid),
        .pack_data  (pack_data),
        .pack_words (pack_words),
        .pack_last  (pack_last)
    );

    frame_checksum u_frame (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .pack_valid   (pack_valid),
        .pack_data    (pack_data),
        .pack_words   (pack_words),
        .pack_last    (pack_last),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_words    (out_words),
        .out_last     (out_last),
        .out_checksum (out_checksum)
    );

endmodule

//--- tb_stream_model.svh
`ifndef TB_STREAM_MODEL_SVH
`define TB_STREAM_MODEL_SVH

localparam int WAIT_LIMIT = 60; // Cycles allowed for any single wait

// Expected beats in output order
stream_pkg::beat_t  exp_data_q[$];
stream_pkg::words_t exp_words_q[$];
logic               exp_last_q[$];
stream_pkg::word_t  exp_sum_q[$];

logic              held_valid  = 1'b0; // Word waiting for its partner
stream_pkg::word_t held_word   = '0;
stream_pkg::word_t run_sum     = '0;   // Packet sum so far, mod 2^32
int                error_count = 0;
int                check_count = 0;
logic              timeout_hit = 1'b0;

function automatic void push_beat(input stream_pkg::beat_t data, input stream_pkg::words_t words,
                                  input logic last, input stream_pkg::word_t sum);
    exp_data_q.push_back(data);
    exp_words_q.push_back(words);
    exp_last_q.push_back(last);
    exp_sum_q.push_back(sum);
endfunction

// Words pair up from the start of each packet, an odd tail goes alone
function automatic void model_accept(input stream_pkg::word_t w, input logic last);
    run_sum = run_sum + w;
    if (held_valid) begin
        push_beat({w, held_word}, 2'd2, last, last ? run_sum : '0);
        held_valid = 1'b0;
    end else if (last) begin
        push_beat({{stream_pkg::WORD_W{1'b0}}, w}, 2'd1, 1'b1, run_sum);
    end else begin
        held_word  = w;
        held_valid = 1'b1;
    end
    if (last) begin
        run_sum = '0;
    end
endfunction

// Everything not yet seen at the output is gone
function automatic void model_flush();
    exp_data_q.delete();
    exp_words_q.delete();
    exp_last_q.delete();
    exp_sum_q.delete();
    held_valid = 1'b0;
    run_sum    = '0;
endfunction

task automatic check_beat(input stream_pkg::beat_t got_data, input stream_pkg::words_t got_words,
                          input logic got_last, input stream_pkg::beat_t exp_data,
                          input stream_pkg::words_t exp_words, input logic exp_last);
    check_count++;
    if (got_data !== exp_data || got_words !== exp_words || got_last !== exp_last) begin
        error_count++;
        $display("[ERROR] %0t: beat %h words %0d last %0b, expected %h words %0d last %0b",
                 $time, got_data, got_words, got_last, exp_data, exp_words, exp_last);
    end
endtask

task automatic check_checksum(input stream_pkg::word_t got, input stream_pkg::word_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("[ERROR] %0t: checksum %h, expected %h", $time, got, exp);
    end
endtask

task automatic check_level(input string what, input stream_pkg::count_t got,
                           input stream_pkg::count_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

// Called at edge plus 1 ns, returns at edge plus 1 ns
task automatic send_word(input stream_pkg::word_t w, input logic last);
    int   waited;
    logic accepted;
    if (timeout_hit) return;
    din_valid = 1'b1;
    din       = w;
    din_last  = last;
    accepted  = 1'b0;
    waited    = 0;
    while (!accepted && waited < WAIT_LIMIT) begin
        @(negedge clk);
        check_bit("frees within depth", frees <= stream_pkg::count_t'(DEPTH), 1'b1);
        if (frees != '0) begin
            check_bit("taken with room left", taken, 1'b1);
        end
        accepted = taken;
        @(posedge clk);
        if (accepted) begin
            model_accept(w, last);
        end
        #1;
        waited++;
    end
    din_valid = 1'b0;
    if (!accepted) begin
        $display("Timeout: word %h was not taken within %0d cycles", w, WAIT_LIMIT);
        timeout_hit = 1'b1;
    end
endtask

task automatic idle_cycles(input int n);
    repeat (n) begin
        @(posedge clk);
        #1;
    end
endtask

task automatic send_packet(input int len);
    int gap;
    for (int i = 0; i < len; i++) begin
        send_word($urandom, i == len - 1);
        gap = ($urandom_range(3, 0) == 0) ? int'($urandom_range(2, 1)) : 0;
        if (gap != 0) begin
            idle_cycles(gap);
        end
    end
endtask

task automatic do_flush();
    flush = 1'b1;
    @(posedge clk);
    model_flush(); // Flush edge
    #1;
    flush = 1'b0;
endtask

task automatic wait_drain();
    int waited;
    if (timeout_hit) return;
    waited = 0;
    while (exp_data_q.size() != 0 && waited < WAIT_LIMIT) begin
        @(posedge clk);
        #1;
        waited++;
    end
    if (exp_data_q.size() != 0) begin
        $display("Timeout: %0d expected beats did not reach the output", exp_data_q.size());
        timeout_hit = 1'b1;
    end
    idle_cycles(4); // Room for any stray beat to show up
endtask

`endif

//--- tb_wide_stream.sv
`timescale 1ns/100ps

module tb_wide_stream;

    localparam int DEPTH = 8;
    localparam int SEED  = 90595;

    logic               clk;
    logic               rst_n;
    logic               flush;
    logic               din_valid;
    stream_pkg::word_t  din;
    logic               din_last;
    logic               taken;
    stream_pkg::count_t frees;
    logic               out_valid;
    stream_pkg::beat_t  out_data;
    stream_pkg::words_t out_words;
    logic               out_last;
    stream_pkg::word_t  out_checksum;

    wide_stream_top #(
        .DEPTH(DEPTH)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .din_valid    (din_valid),
        .din          (din),
        .din_last     (din_last),
        .taken        (taken),
        .frees        (frees),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_words    (out_words),
        .out_last     (out_last),
        .out_checksum (out_checksum)
    );

    `include "tb_stream_model.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Outputs are settled at the falling edge
    initial begin : output_monitor
        stream_pkg::beat_t  e_data;
        stream_pkg::words_t e_words;
        logic               e_last;
        stream_pkg::word_t  e_sum;
        forever begin
            @(negedge clk);
            if (rst_n && out_valid) begin
                if (exp_data_q.size() == 0) begin
                    error_count++;
                    $display("Unexpected output beat %h at %0t with no beat pending",
                             out_data, $time);
                end else begin
                    e_data  = exp_data_q.pop_front();
                    e_words = exp_words_q.pop_front();
                    e_last  = exp_last_q.pop_front();
                    e_sum   = exp_sum_q.pop_front();
                    check_beat(out_data, out_words, out_last, e_data, e_words, e_last);
                    check_checksum(out_checksum, e_sum);
                end
            end
        end
    end

    task automatic report_test(input string name, input int errs_before, input int checks_before);
        $display("Test %s: %0d checks, %0d mismatches%s", name, check_count - checks_before,
                 error_count - errs_before, timeout_hit ? ", stopped by timeout" : "");
    endtask

    task automatic run_reset_test();
        int e0;
        int c0;
        e0 = error_count;
        c0 = check_count;
        @(negedge clk);
        check_bit("taken after reset", taken, 1'b1);
        check_level("frees after reset", frees, stream_pkg::count_t'(DEPTH));
        repeat (10) begin
            @(negedge clk);
            check_bit("out_valid with no input", out_valid, 1'b0);
        end
        idle_cycles(1);
        report_test("reset", e0, c0);
    endtask

    task automatic run_even_test();
        int e0;
        int c0;
        e0 = error_count;
        c0 = check_count;
        for (int p = 0; p < 12 && !timeout_hit; p++) begin
            send_packet(2 * int'($urandom_range(4, 1)));
            idle_cycles(int'($urandom_range(3, 0)));
        end
        wait_drain();
        report_test("even packets", e0, c0);
    endtask

    task automatic run_odd_test();
        int e0;
        int c0;
        e0 = error_count;
        c0 = check_count;
        send_packet(1); // Lone word first
        send_packet(1);
        for (int p = 0; p < 12 && !timeout_hit; p++) begin
            send_packet(2 * int'($urandom_range(4, 0)) + 1);
            idle_cycles(int'($urandom_range(3, 0)));
        end
        wait_drain();
        report_test("odd packets", e0, c0);
    endtask

    task automatic run_checksum_test();
        int e0;
        int c0;
        e0 = error_count;
        c0 = check_count;
        for (int p = 0; p < 30 && !timeout_hit; p++) begin
            send_packet(int'($urandom_range(9, 1)));
            if ($urandom_range(1, 0) == 1) begin
                idle_cycles(int'($urandom_range(3, 1)));
            end
        end
        wait_drain();
        report_test("mixed lengths and checksums", e0, c0);
    endtask

    task automatic run_flush_test();
        int e0;
        int c0;
        int partial;
        e0 = error_count;
        c0 = check_count;
        for (int r = 0; r < 6 && !timeout_hit; r++) begin
            send_packet(int'($urandom_range(9, 1)));
            partial = int'($urandom_range(5, 1));
            for (int i = 0; i < partial; i++) begin
                send_word($urandom, 1'b0); // Packet left open
            end
            idle_cycles(int'($urandom_range(2, 0)));
            do_flush();
            @(negedge clk);
            check_level("frees after flush", frees, stream_pkg::count_t'(DEPTH));
            idle_cycles(1);
            send_packet(int'($urandom_range(9, 1))); // Sum must restart at zero
            wait_drain();
        end
        report_test("flush mid packet", e0, c0);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n      = 1'b0;
        flush      = 1'b0;
        din_valid  = 1'b0;
        din        = '0;
        din_last   = 1'b0;
        repeat (5) begin
            @(posedge clk);
        end
        #1;
        rst_n = 1'b1;
        run_reset_test();
        run_even_test();
        run_odd_test();
        run_checksum_test();
        run_flush_test();
        $display("Summary: %0d checks, %0d mismatches, timeout %0s", check_count, error_count,
                 timeout_hit ? "yes" : "no");
        if (error_count == 0 && !timeout_hit) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+.
stream_pkg.sv
multififo_w1_r2.sv
pair_packer.sv
frame_checksum.sv
wide_stream_top.sv
tb_wide_stream.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the wide stream testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/sim_wide_stream

if ! verilator --binary --timing --assert -f flist.f \
        --top-module tb_wide_stream -o sim_wide_stream; then
    echo "Verilator build failed"
    exit 1
fi

if ! "$BIN" > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with a failing status"
    exit 1
fi

cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi

if ! grep -q "Finished with no errors" "$LOG"; then
    echo "Simulation did not reach its final report"
    exit 1
fi

echo "Simulation passed"
exit 0
